// File: common/adc_cfg_pkg.sv
package adc_cfg_pkg;

  // one serial frame, sent msb first
  typedef struct packed {
    logic [2:0]  addr;
    logic [15:0] data;
  } adc_cfg_word_t;

  // adc side pins of the subsystem
  typedef struct packed {
    logic ddrb;       // ddr bypass to the adc
    logic dcm_reset;  // stretched reset for the clock manager
    logic mode;
    logic sclk;       // three-wire serial clock
    logic strb;       // three-wire strobe, active low
    logic sdata;      // three-wire serial data
  } adc_pins_t;

  // host override levels, packed as ctrl register bits [2:0]
  typedef struct packed {
    logic request;  // bit 2, host owns the pins
    logic ddrb;     // bit 1
    logic mode;     // bit 0
  } adc_host_ctl_t;

  // host register map
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_WORD   = 2'd1;
  localparam logic [1:0] REG_STATUS = 2'd2;

  // power-up configuration data for address 0
  localparam logic [15:0] AUTO_WORD_SINGLE      = 16'h7cbc;
  localparam logic [15:0] AUTO_WORD_INTERLEAVED = 16'h7c2c;

  localparam int CFG_FRAME_BITS = 19;  // addr plus data

endpackage

// File: hw/adc_config/adc_3wire_ser.sv
`timescale 1ns/100ps

module adc_3wire_ser #(
  parameter int SCLK_DIV_BITS = 7
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  adc_cfg_pkg::adc_cfg_word_t word_i,
  output logic                       busy_o,
  output logic                       sclk_o,
  output logic                       strb_o,
  output logic                       sdata_o
);

  localparam int FRAME_BITS = adc_cfg_pkg::CFG_FRAME_BITS;
  localparam int CNT_BITS   = $clog2(FRAME_BITS);

  typedef enum logic [2:0] {
    S_IDLE,    // nothing to send
    S_WAIT,    // align to the next sclk fall
    S_STRB0,   // one period with strobe off
    S_DATA,    // frame bits, msb first
    S_COMMIT,  // commit bit, sdata 0
    S_STRB1,   // strobe off again
    S_HOLD     // one period before going idle
  } ser_state_e;

  ser_state_e              state;
  logic [SCLK_DIV_BITS-1:0] div_cnt;
  logic                     wrap;
  logic [FRAME_BITS-1:0]    shift_q;
  logic [CNT_BITS-1:0]      bit_cnt;

  assign wrap = &div_cnt;  // sclk falls right after this

  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;  // free running
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      bit_cnt <= '0;
    end else if (state == S_IDLE) begin
      if (start_i) begin
        state   <= S_WAIT;
        bit_cnt <= '0;
      end
    end else if (wrap) begin
      case (state)
        S_WAIT:   state <= S_STRB0;
        S_STRB0:  state <= S_DATA;
        S_DATA: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_BITS'(FRAME_BITS - 1)) begin
            state <= S_COMMIT;
          end
        end
        S_COMMIT: state <= S_STRB1;
        S_STRB1:  state <= S_HOLD;
        S_HOLD:   state <= S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  // zeros shift in behind the frame, so the commit bit comes out as 0
  always_ff @(posedge clk) begin
    if (start_i && state == S_IDLE) begin
      shift_q <= word_i;
    end else if (wrap && state == S_DATA) begin
      shift_q <= shift_q << 1;
    end
  end

  assign busy_o  = (state != S_IDLE);
  assign sclk_o  = (state == S_IDLE || state == S_WAIT) ? 1'b0 : div_cnt[SCLK_DIV_BITS-1];
  assign strb_o  = !(state == S_DATA || state == S_COMMIT);
  assign sdata_o = shift_q[FRAME_BITS-1];

  // the strobe never opens on the cycle a frame is accepted
  a_strb_in_frame: assert property (@(posedge clk) disable iff (rst)
    !strb_o |-> busy_o && $past(busy_o));

  // sclk stays low while idle and on the cycle after
  a_sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
    !busy_o |-> !sclk_o ##1 !sclk_o);

endmodule

// File: hw/adc_config/adc_auto_config.sv
`timescale 1ns/100ps

module adc_auto_config #(
  parameter int INTERLEAVED = 0
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       busy_i,
  output logic                       start_o,
  output adc_cfg_pkg::adc_cfg_word_t word_o,
  output logic                       mode_o,
  output logic                       ddrb_o,
  output logic                       done_o
);

  typedef enum logic [2:0] {
    C_MODE_CLEAR,
    C_MODE_SET,
    C_LOAD,   // start pulse to the serializer
    C_WAIT,   // frame in flight
    C_DDRB,   // one ddrb pulse
    C_DONE
  } conf_state_e;

  conf_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= C_MODE_CLEAR;
    end else begin
      case (state)
        C_MODE_CLEAR: state <= C_MODE_SET;
        C_MODE_SET:   state <= C_LOAD;
        C_LOAD:       state <= C_WAIT;
        C_WAIT: begin
          if (!busy_i) begin
            state <= C_DDRB;  // busy fell, frame committed
          end
        end
        C_DDRB:       state <= C_DONE;
        default:      state <= C_DONE;  // stays here until reset
      endcase
    end
  end

  assign mode_o      = (state != C_MODE_CLEAR);
  assign start_o     = (state == C_LOAD);
  assign ddrb_o      = (state == C_DDRB);
  assign done_o      = (state == C_DONE);
  assign word_o.addr = 3'd0;
  assign word_o.data = (INTERLEAVED != 0) ? adc_cfg_pkg::AUTO_WORD_INTERLEAVED
                                          : adc_cfg_pkg::AUTO_WORD_SINGLE;

  a_ddrb_single: assert property (@(posedge clk) disable iff (rst)
    ddrb_o |=> !ddrb_o);

endmodule

// File: hw/adc_config/adc_config_mux.sv
`timescale 1ns/100ps

module adc_config_mux #(
  parameter int INTERLEAVED   = 0,
  parameter int SCLK_DIV_BITS = 7,
  parameter int DCM_EXT_LEN   = 5
) (
  input  logic                       clk,
  input  logic                       rst,
  input  adc_cfg_pkg::adc_host_ctl_t host_ctl_i,
  input  logic                       host_start_i,
  input  adc_cfg_pkg::adc_cfg_word_t host_word_i,
  output logic                       busy_o,
  output logic                       auto_done_o,
  output adc_cfg_pkg::adc_pins_t     pins_o
);

  adc_cfg_pkg::adc_cfg_word_t auto_word;
  adc_cfg_pkg::adc_cfg_word_t sel_word;
  logic                       auto_start;
  logic                       auto_mode;
  logic                       auto_ddrb;
  logic                       sel_start;
  logic                       sel_mode;
  logic                       sel_ddrb;
  logic                       ddrb_q;
  logic [DCM_EXT_LEN-1:0]     dcm_stretch;
  logic                       ser_sclk;
  logic                       ser_strb;
  logic                       ser_sdata;

  // host wins whenever request is set
  assign sel_ddrb  = host_ctl_i.request ? host_ctl_i.ddrb : auto_ddrb;
  assign sel_mode  = host_ctl_i.request ? host_ctl_i.mode : auto_mode;
  assign sel_start = host_ctl_i.request ? host_start_i    : auto_start;
  assign sel_word  = host_ctl_i.request ? host_word_i     : auto_word;

  adc_auto_config #(
    .INTERLEAVED(INTERLEAVED)
  ) u_auto (
    .clk    (clk),
    .rst    (rst),
    .busy_i (busy_o),
    .start_o(auto_start),
    .word_o (auto_word),
    .mode_o (auto_mode),
    .ddrb_o (auto_ddrb),
    .done_o (auto_done_o)
  );

  adc_3wire_ser #(
    .SCLK_DIV_BITS(SCLK_DIV_BITS)
  ) u_ser (
    .clk    (clk),
    .rst    (rst),
    .start_i(sel_start),
    .word_i (sel_word),
    .busy_o (busy_o),
    .sclk_o (ser_sclk),
    .strb_o (ser_strb),
    .sdata_o(ser_sdata)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      ddrb_q      <= 1'b0;
      dcm_stretch <= '0;
    end else begin
      ddrb_q <= sel_ddrb;  // pin register
      if (sel_ddrb) begin
        dcm_stretch <= '1;
      end else begin
        dcm_stretch <= dcm_stretch << 1;  // drains one per clock
      end
    end
  end

  always_comb begin
    pins_o.ddrb      = ddrb_q;
    pins_o.dcm_reset = dcm_stretch[DCM_EXT_LEN-1];
    pins_o.mode      = sel_mode;
    pins_o.sclk      = ser_sclk;
    pins_o.strb      = ser_strb;
    pins_o.sdata     = ser_sdata;
  end

  a_dcm_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(pins_o.dcm_reset) |-> $past(sel_ddrb));

endmodule

// File: hw/adc_host_regs.sv
`timescale 1ns/100ps

module adc_host_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wr_en_i,
  input  logic [1:0]                 wr_addr_i,
  input  logic [31:0]                wr_data_i,
  input  logic [1:0]                 rd_addr_i,
  output logic [31:0]                rd_data_o,
  input  logic                       busy_i,
  input  logic                       auto_done_i,
  output adc_cfg_pkg::adc_host_ctl_t host_ctl_o,
  output adc_cfg_pkg::adc_cfg_word_t host_word_o,
  output logic                       host_start_o
);

  localparam int WORD_BITS = adc_cfg_pkg::CFG_FRAME_BITS;
  localparam int CTL_BITS  = $bits(adc_cfg_pkg::adc_host_ctl_t);

  logic ctrl_wr;
  logic word_wr;

  assign ctrl_wr = wr_en_i && (wr_addr_i == adc_cfg_pkg::REG_CTRL);
  assign word_wr = wr_en_i && (wr_addr_i == adc_cfg_pkg::REG_WORD);

  always_ff @(posedge clk) begin
    if (rst) begin
      host_ctl_o   <= '0;  // request low, host owns nothing
      host_start_o <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        host_ctl_o <= adc_cfg_pkg::adc_host_ctl_t'(wr_data_i[CTL_BITS-1:0]);
      end
      host_start_o <= word_wr;  // one cycle after the write
    end
  end

  always_ff @(posedge clk) begin
    if (word_wr) begin
      host_word_o <= adc_cfg_pkg::adc_cfg_word_t'(wr_data_i[WORD_BITS-1:0]);
    end
  end

  always_comb begin
    case (rd_addr_i)
      adc_cfg_pkg::REG_CTRL:   rd_data_o = {{(32 - CTL_BITS){1'b0}}, host_ctl_o};
      adc_cfg_pkg::REG_WORD:   rd_data_o = {{(32 - WORD_BITS){1'b0}}, host_word_o};
      adc_cfg_pkg::REG_STATUS: rd_data_o = {30'd0, auto_done_i, busy_i};
      default:                 rd_data_o = 32'd0;
    endcase
  end

endmodule

// File: hw/adc_ctrl_top.sv
`timescale 1ns/100ps

module adc_ctrl_top #(
  parameter int INTERLEAVED   = 0,
  parameter int SCLK_DIV_BITS = 7,
  parameter int DCM_EXT_LEN   = 5
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en_i,
  input  logic [1:0]             wr_addr_i,
  input  logic [31:0]            wr_data_i,
  input  logic [1:0]             rd_addr_i,
  output logic [31:0]            rd_data_o,
  output adc_cfg_pkg::adc_pins_t pins_o
);

  adc_cfg_pkg::adc_host_ctl_t host_ctl;
  adc_cfg_pkg::adc_cfg_word_t host_word;
  logic                       host_start;
  logic                       busy;
  logic                       auto_done;

  adc_host_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .busy_i      (busy),
    .auto_done_i (auto_done),
    .host_ctl_o  (host_ctl),
    .host_word_o (host_word),
    .host_start_o(host_start)
  );

  adc_config_mux #(
    .INTERLEAVED  (INTERLEAVED),
    .SCLK_DIV_BITS(SCLK_DIV_BITS),
    .DCM_EXT_LEN  (DCM_EXT_LEN)
  ) u_mux (
    .clk         (clk),
    .rst         (rst),
    .host_ctl_i  (host_ctl),
    .host_start_i(host_start),
    .host_word_i (host_word),
    .busy_o      (busy),
    .auto_done_o (auto_done),
    .pins_o      (pins_o)
  );

endmodule

// File: verif/tb_adc_ctrl.sv
`timescale 1ns/100ps

module tb_adc_ctrl;

  localparam int INTERLEAVED    = 0;
  localparam int SCLK_DIV_BITS  = 7;
  localparam int DCM_EXT_LEN    = 5;
  localparam int FRAME_BITS     = adc_cfg_pkg::CFG_FRAME_BITS;
  localparam int ROWS           = 5;
  localparam int TIMEOUT_CYCLES = (ROWS + 2) * 24 * (1 << SCLK_DIV_BITS) + 500;

  logic                       clk;
  logic                       rst;
  logic                       wr_en;
  logic [1:0]                 wr_addr;
  logic [31:0]                wr_data;
  logic [1:0]                 rd_addr;
  logic [31:0]                rd_data;
  adc_cfg_pkg::adc_pins_t     pins;
  logic                       mon_sclk;
  logic [FRAME_BITS:0]        frame_bits;   // payload plus commit bit
  int                         bit_count;
  int                         frame_count;
  adc_cfg_pkg::adc_cfg_word_t captured;
  logic                       commit_bit;
  int                         errors;
  int                         cycle_count;
  integer                     seed;
  logic [31:0]                rnd;
  adc_cfg_pkg::adc_cfg_word_t wr_word [ROWS];
  adc_cfg_pkg::adc_cfg_word_t follow_word [ROWS];  // written while busy
  adc_cfg_pkg::adc_cfg_word_t exp_frame [ROWS];
  logic                       drop [ROWS];
  adc_cfg_pkg::adc_cfg_word_t exp_auto;
  int                         frames_before;
  int                         dcm_left;
  int                         i;

  adc_ctrl_top #(
    .INTERLEAVED  (INTERLEAVED),
    .SCLK_DIV_BITS(SCLK_DIV_BITS),
    .DCM_EXT_LEN  (DCM_EXT_LEN)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .wr_en_i  (wr_en),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .rd_addr_i(rd_addr),
    .rd_data_o(rd_data),
    .pins_o   (pins)
  );

  always #20 clk = ~clk;

  assign mon_sclk = pins.sclk;

  // adc side capture, bits are taken on the rising sclk
  always @(posedge mon_sclk) begin
    if (!pins.strb) begin
      frame_bits = {frame_bits[FRAME_BITS-1:0], pins.sdata};
      bit_count  = bit_count + 1;
      if (bit_count == FRAME_BITS + 1) begin
        captured    = adc_cfg_pkg::adc_cfg_word_t'(frame_bits[FRAME_BITS:1]);
        commit_bit  = frame_bits[0];
        frame_count = frame_count + 1;
        bit_count   = 0;
      end
    end
  end

  // serial lines rest while the serializer is idle
  always @(negedge clk) begin
    if (!rst && !uut.busy) begin
      check_bit("sclk idle", pins.sclk, 1'b0);
      check_bit("strb idle", pins.strb, 1'b1);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d", errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_word(input string name, input adc_cfg_pkg::adc_cfg_word_t act,
                            input adc_cfg_pkg::adc_cfg_word_t exp);
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s: expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s: expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_status(input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t rd_data_o: expected %h actual %h", $time, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp) begin
      errors++;
      $display("FAILED %0t %s: expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;  // drive and sample just after the edge
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    step();
    wr_en   = 1'b0;
  endtask

  task automatic wait_busy(input logic level);
    while (rd_data[0] !== level) step();  // rd_addr stays on the status register
  endtask

  // dcm_reset length counted from the ddrb_o rise
  task automatic measure_stretch(input int exp_ddrb);
    int ddrb_len;
    int dcm_len;
    ddrb_len = 0;
    dcm_len  = 0;
    while (!pins.ddrb) step();
    check_bit("dcm_reset", pins.dcm_reset, 1'b1);
    while (pins.ddrb || pins.dcm_reset) begin
      if (pins.ddrb) ddrb_len++;
      if (pins.dcm_reset) dcm_len++;
      step();
    end
    check_count("ddrb_o pulse", ddrb_len, exp_ddrb);
    check_count("dcm_reset length", dcm_len, exp_ddrb + DCM_EXT_LEN - 1);
  endtask

  task automatic build_table();
    for (int r = 0; r < ROWS; r++) begin
      rnd            = $random(seed);
      wr_word[r]     = adc_cfg_pkg::adc_cfg_word_t'(rnd[FRAME_BITS-1:0]);
      rnd            = $random(seed);
      follow_word[r] = adc_cfg_pkg::adc_cfg_word_t'(rnd[FRAME_BITS-1:0]);
      drop[r]        = (r == 2);
      exp_frame[r]   = wr_word[r];  // a start while busy never replaces the frame
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    rd_addr     = adc_cfg_pkg::REG_STATUS;
    frame_bits  = '0;
    bit_count   = 0;
    frame_count = 0;
    errors      = 0;
    cycle_count = 0;
    seed        = 32'h8fa4;
    build_table();
    exp_auto.addr = 3'd0;
    exp_auto.data = adc_cfg_pkg::AUTO_WORD_SINGLE;  // uut is a single, non-interleaved adc
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;

    // power-up sequence
    check_bit("mode", pins.mode, 1'b0);
    check_bit("ddrb_o", pins.ddrb, 1'b0);
    check_bit("dcm_reset", pins.dcm_reset, 1'b0);
    step();
    check_bit("mode", pins.mode, 1'b1);
    while (frame_count < 1) step();
    check_word("auto frame", captured, exp_auto);
    check_bit("commit bit", commit_bit, 1'b0);
    measure_stretch(1);
    check_status(rd_data, {30'd0, 1'b1, 1'b0});  // auto_done set, busy clear

    // host takes over, mode high
    write_reg(adc_cfg_pkg::REG_CTRL, 32'h5);
    check_bit("mode", pins.mode, 1'b1);
    for (i = 0; i < ROWS; i++) begin
      frames_before = frame_count;
      write_reg(adc_cfg_pkg::REG_WORD, {13'd0, wr_word[i]});
      wait_busy(1'b1);
      if (drop[i]) write_reg(adc_cfg_pkg::REG_WORD, {13'd0, follow_word[i]});
      wait_busy(1'b0);
      check_count("frame_count", frame_count, frames_before + 1);
      check_word("host frame", captured, exp_frame[i]);
      check_bit("commit bit", commit_bit, 1'b0);
    end

    // host override of mode and ddrb
    write_reg(adc_cfg_pkg::REG_CTRL, 32'h4);
    check_bit("mode", pins.mode, 1'b0);
    write_reg(adc_cfg_pkg::REG_CTRL, 32'h6);
    check_bit("ddrb_o", pins.ddrb, 1'b0);  // pin follows one clock later
    step();
    check_bit("ddrb_o", pins.ddrb, 1'b1);
    check_bit("dcm_reset", pins.dcm_reset, 1'b1);
    write_reg(adc_cfg_pkg::REG_CTRL, 32'h5);
    check_bit("mode", pins.mode, 1'b1);
    check_bit("ddrb_o", pins.ddrb, 1'b1);
    step();
    check_bit("ddrb_o", pins.ddrb, 1'b0);
    dcm_left = 0;
    while (pins.dcm_reset) begin
      dcm_left++;
      step();
    end
    check_count("dcm_reset tail", dcm_left, DCM_EXT_LEN - 1);

    // stored registers read back
    rd_addr = adc_cfg_pkg::REG_CTRL;
    step();
    check_status(rd_data, 32'h5);
    rd_addr = adc_cfg_pkg::REG_WORD;
    step();
    check_status(rd_data, {13'd0, wr_word[ROWS-1]});

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
common/adc_cfg_pkg.sv
hw/adc_config/adc_3wire_ser.sv
hw/adc_config/adc_auto_config.sv
hw/adc_config/adc_config_mux.sv
hw/adc_host_regs.sv
hw/adc_ctrl_top.sv
verif/tb_adc_ctrl.sv

// File: run_sim.sh
#!/bin/bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert --top-module tb_adc_ctrl \
       -f src.f -o tb_adc_ctrl \
  && ./obj_dir/tb_adc_ctrl | tee sim.log \
  && grep -q "^STATUS: PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
